// File: hdl/memWb_defines.svh
`ifndef MEMWB_DEFINES_SVH
`define MEMWB_DEFINES_SVH

// --------------------------------------------------
// Datapath widths.
// --------------------------------------------------
`define DATA_WIDTH 32
`define ADDR_WIDTH 32
`define REG_ADDR_WIDTH 5

// Data memory depth in 32-bit words.
`define MEM_WORDS 256

// --------------------------------------------------
// How far fetch has run ahead of this stage.
// --------------------------------------------------
`define PC_BRANCH_LAG 3
`define PC_LINK_LAG 2

`endif

// File: hdl/memWbPkg.sv
`include "memWb_defines.svh"

package memWbPkg;

	// Stage action for the current command.
	typedef enum logic [2:0]
	{
		Idle            = 3'd0,
		RegWrite        = 3'd1,
		MemReadRegWrite = 3'd2,
		MemWrite        = 3'd3,
		PcSelectWrite   = 3'd4,
		PcWrite         = 3'd5,
		LuiRegWrite     = 3'd6
	} stateT;

	// One decoded command per cycle.
	typedef struct packed
	{
		stateT                      state;
		logic [`DATA_WIDTH-1:0]     aluResult;
		logic [`DATA_WIDTH-1:0]     imm;
		logic [2:0]                 func3;
		logic [`REG_ADDR_WIDTH-1:0] rs1;
		logic [`REG_ADDR_WIDTH-1:0] rs2;
		logic [`REG_ADDR_WIDTH-1:0] rd;
		logic                       forwardStore;
	} commandT;

	// Register file write port.
	typedef struct packed
	{
		logic                       enable;
		logic [`REG_ADDR_WIDTH-1:0] rd;
		logic [`DATA_WIDTH-1:0]     value;
	} writeBackT;

	// A memory word seen whole, as halfwords or as bytes.
	typedef union packed
	{
		logic [`DATA_WIDTH-1:0] word;
		logic [1:0][15:0]       halves;
		logic [3:0][7:0]        bytes;
	} memWordT;

endpackage

// File: hdl/dataMemory.sv
`timescale 1ns/1ps
`include "memWb_defines.svh"

module dataMemory
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   read,
	input  logic                   write,
	input  logic [`ADDR_WIDTH-1:0] addr,
	input  logic [2:0]             func3,
	input  logic [`DATA_WIDTH-1:0] writeData,
	output logic [`DATA_WIDTH-1:0] readData,
	output logic [3:0]             strobe
);

	localparam int IndexWidth = $clog2(`MEM_WORDS);

	memWbPkg::memWordT     mem [`MEM_WORDS];
	memWbPkg::memWordT     readWord;
	memWbPkg::memWordT     storeLanes;
	logic [IndexWidth-1:0] wordIndex;
	logic [7:0]            loadByte;
	logic [15:0]           loadHalf;

	assign wordIndex = addr[IndexWidth+1:2];
	assign readWord  = mem[wordIndex];

	// --------------------------------------------------
	// Stores.
	// --------------------------------------------------
	always_comb
	begin
		strobe = 4'b0000;
		if (write)
		begin
			case (func3[1:0])
				2'b00:   strobe = 4'b0001 << addr[1:0];
				2'b01:   strobe = addr[1] ? 4'b1100 : 4'b0011;
				default: strobe = 4'b1111;
			endcase
		end
	end

	// Replicate narrow data so every lane carries it.
	always_comb
	begin
		case (func3[1:0])
			2'b00:   storeLanes.word = {4{writeData[7:0]}};
			2'b01:   storeLanes.word = {2{writeData[15:0]}};
			default: storeLanes.word = writeData;
		endcase
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
		begin
			if (strobe[i])
				mem[wordIndex].bytes[i] <= storeLanes.bytes[i];
		end
	end

	// --------------------------------------------------
	// Loads.
	// --------------------------------------------------
	assign loadByte = readWord.bytes[addr[1:0]];
	assign loadHalf = readWord.halves[addr[1]];

	// func3[2] selects zero extension.
	always_comb
	begin
		readData = '0;
		if (read)
		begin
			case (func3[1:0])
				2'b00:
					readData = {{(`DATA_WIDTH-8){loadByte[7] & ~func3[2]}}, loadByte};
				2'b01:
					readData = {{(`DATA_WIDTH-16){loadHalf[15] & ~func3[2]}}, loadHalf};
				default:
					readData = readWord.word;
			endcase
		end
	end

	// Halfwords and words must be naturally aligned.
	assert property (@(posedge clk) disable iff (reset)
		(read || write) |->
			!((func3[1:0] == 2'b01 && addr[0]) || (func3[1:0] == 2'b10 && addr[1:0] != 2'b00)));

endmodule

// File: hdl/registerFile.sv
`timescale 1ns/1ps
`include "memWb_defines.svh"

module registerFile
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic [`REG_ADDR_WIDTH-1:0] rs1,
	input  logic [`REG_ADDR_WIDTH-1:0] rs2,
	input  memWbPkg::writeBackT        write,
	output logic [`DATA_WIDTH-1:0]     rs1Data,
	output logic [`DATA_WIDTH-1:0]     rs2Data
);

	localparam int RegCount = 1 << `REG_ADDR_WIDTH;

	logic [`DATA_WIDTH-1:0] regs [RegCount];

	// --------------------------------------------------
	// Write port.
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < RegCount; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (write.enable && write.rd != '0)
		begin
			regs[write.rd] <= write.value;
		end
	end

	// --------------------------------------------------
	// Read ports.
	// --------------------------------------------------
	// Old value is seen during the write cycle.
	// Register zero is cleared in reset and never written.
	assign rs1Data = regs[rs1];
	assign rs2Data = regs[rs2];

endmodule

// File: hdl/memWbController.sv
`timescale 1ns/1ps
`include "memWb_defines.svh"

module memWbController
(
	input  logic                   clk,
	input  logic                   reset,
	input  memWbPkg::commandT      cmd,
	input  logic [`ADDR_WIDTH-1:0] pc,
	input  logic [`DATA_WIDTH-1:0] rs1Data,
	input  logic [`DATA_WIDTH-1:0] rs2Data,
	input  logic [`DATA_WIDTH-1:0] loadData,
	output logic                   pcWriteEnable,
	output logic [`ADDR_WIDTH-1:0] pcWriteData,
	output memWbPkg::writeBackT    regWrite,
	output logic                   memRead,
	output logic                   memWrite,
	output logic [`ADDR_WIDTH-1:0] memAddr,
	output logic [`DATA_WIDTH-1:0] memWriteData,
	output logic [`DATA_WIDTH-1:0] resultData
);

	// Entry k holds the PC presented k cycles ago.
	logic [`PC_BRANCH_LAG:1][`ADDR_WIDTH-1:0] pcHistory;
	logic [`DATA_WIDTH-1:0]                   lastResult;
	logic [`DATA_WIDTH-1:0]                   storeData;

	assign storeData = cmd.forwardStore ? lastResult : rs2Data;

	// --------------------------------------------------
	// State decode.
	// --------------------------------------------------
	always_comb
	begin
		pcWriteEnable   = 1'b0;
		pcWriteData     = '0;
		regWrite.enable = 1'b0;
		regWrite.rd     = cmd.rd;
		regWrite.value  = '0;
		memRead         = 1'b0;
		memWrite        = 1'b0;
		memAddr         = cmd.aluResult;
		memWriteData    = storeData;
		if (reset)
		begin
			// Clear the fetch PC.
			pcWriteEnable = 1'b1;
		end
		else
		begin
			case (cmd.state)
				memWbPkg::RegWrite:
				begin
					regWrite.enable = 1'b1;
					regWrite.value  = cmd.aluResult;
				end
				memWbPkg::LuiRegWrite:
				begin
					regWrite.enable = 1'b1;
					regWrite.value  = cmd.imm;
				end
				memWbPkg::MemReadRegWrite:
				begin
					memRead         = 1'b1;
					regWrite.enable = 1'b1;
					regWrite.value  = loadData;
				end
				memWbPkg::MemWrite:
				begin
					memWrite = 1'b1;
				end
				memWbPkg::PcSelectWrite:
				begin
					// Branch is taken when the ALU compare is nonzero.
					if (cmd.aluResult != '0)
					begin
						pcWriteEnable = 1'b1;
						pcWriteData   = pcHistory[`PC_BRANCH_LAG] + cmd.imm;
					end
				end
				memWbPkg::PcWrite:
				begin
					pcWriteEnable   = 1'b1;
					pcWriteData     = cmd.aluResult;
					regWrite.enable = 1'b1;
					regWrite.value  = pcHistory[`PC_LINK_LAG];
				end
				default:
				begin
				end
			endcase
		end
	end

	assign resultData = memWrite ? storeData : regWrite.value;

	// --------------------------------------------------
	// PC delay line and last result.
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pcHistory  <= '0;
			lastResult <= '0;
		end
		else
		begin
			pcHistory <= {pcHistory[`PC_BRANCH_LAG-1:1], pc};
			if (cmd.state != memWbPkg::Idle)
				lastResult <= resultData;
		end
	end

	// Loads and stores never share a cycle.
	assert property (@(posedge clk) disable iff (reset) !(memRead && memWrite));

	// In reset the PC is cleared and nothing else is written.
	assert property (@(posedge clk)
		reset |-> (pcWriteEnable && pcWriteData == '0 && !regWrite.enable && !memWrite));

	// A write to x0 still reads back as zero.
	assert property (@(posedge clk) disable iff (reset)
		(regWrite.enable && regWrite.rd == '0) |=> (cmd.rs1 != '0 || rs1Data == '0));

endmodule

// File: hdl/memWbUnit.sv
`timescale 1ns/1ps
`include "memWb_defines.svh"

module memWbUnit
(
	input  logic                   clk,
	input  logic                   reset,
	input  memWbPkg::commandT      cmd,
	input  logic [`ADDR_WIDTH-1:0] pc,
	output logic                   pcWriteEnable,
	output logic [`ADDR_WIDTH-1:0] pcWriteData,
	output memWbPkg::writeBackT    regWrite,
	output logic [3:0]             storeStrobe,
	output logic [`ADDR_WIDTH-1:0] storeAddr,
	output logic [`DATA_WIDTH-1:0] resultData
);

	logic [`DATA_WIDTH-1:0] rs1Data;
	logic [`DATA_WIDTH-1:0] rs2Data;
	logic [`DATA_WIDTH-1:0] loadData;
	logic [`DATA_WIDTH-1:0] memWriteData;
	logic                   memRead;
	logic                   memWrite;

	memWbController controller
	(
		.clk           (clk),
		.reset         (reset),
		.cmd           (cmd),
		.pc            (pc),
		.rs1Data       (rs1Data),
		.rs2Data       (rs2Data),
		.loadData      (loadData),
		.pcWriteEnable (pcWriteEnable),
		.pcWriteData   (pcWriteData),
		.regWrite      (regWrite),
		.memRead       (memRead),
		.memWrite      (memWrite),
		.memAddr       (storeAddr),
		.memWriteData  (memWriteData),
		.resultData    (resultData)
	);

	registerFile regFile
	(
		.clk     (clk),
		.reset   (reset),
		.rs1     (cmd.rs1),
		.rs2     (cmd.rs2),
		.write   (regWrite),
		.rs1Data (rs1Data),
		.rs2Data (rs2Data)
	);

	dataMemory dataMem
	(
		.clk       (clk),
		.reset     (reset),
		.read      (memRead),
		.write     (memWrite),
		.addr      (storeAddr),
		.func3     (cmd.func3),
		.writeData (memWriteData),
		.readData  (loadData),
		.strobe    (storeStrobe)
	);

endmodule

// File: verif/memWbTb.sv
`timescale 1ns/1ps
`include "memWb_defines.svh"

module memWbTb;

	localparam int IndexWidth    = $clog2(`MEM_WORDS);
	localparam int DirectedCount = 4 + 6 + 53 + 5 + 6;
	localparam int RandomSetup   = 31 + 16;
	localparam int RandomCount   = 400;
	localparam int CycleLimit    = 2 * (DirectedCount + RandomSetup + RandomCount) + 100;

	typedef struct packed
	{
		logic                   pcWriteEnable;
		logic [`ADDR_WIDTH-1:0] pcWriteData;
		memWbPkg::writeBackT    regWrite;
		logic [3:0]             storeStrobe;
		logic [`DATA_WIDTH-1:0] resultData;
	} expectT;

	logic                   clk;
	logic                   reset;
	memWbPkg::commandT      cmd;
	logic [`ADDR_WIDTH-1:0] pc;
	logic                   pcWriteEnable;
	logic [`ADDR_WIDTH-1:0] pcWriteData;
	memWbPkg::writeBackT    regWrite;
	logic [3:0]             storeStrobe;
	logic [`ADDR_WIDTH-1:0] storeAddr;
	logic [`DATA_WIDTH-1:0] resultData;

	// Model state, advanced once per cycle by expectFor.
	logic [`DATA_WIDTH-1:0] modelRegs [32];
	logic [`DATA_WIDTH-1:0] modelMem [`MEM_WORDS];
	logic [`ADDR_WIDTH-1:0] modelPcs [1:`PC_BRANCH_LAG];
	logic [`DATA_WIDTH-1:0] modelLast;

	logic [`ADDR_WIDTH-1:0] nextPc;
	string                  testName;
	int                     errorCount;
	int                     testErrors;
	int                     testCount;
	int                     commandCount;
	int                     cycleCount;

	memWbUnit dut_i
	(
		.clk           (clk),
		.reset         (reset),
		.cmd           (cmd),
		.pc            (pc),
		.pcWriteEnable (pcWriteEnable),
		.pcWriteData   (pcWriteData),
		.regWrite      (regWrite),
		.storeStrobe   (storeStrobe),
		.storeAddr     (storeAddr),
		.resultData    (resultData)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// --------------------------------------------------
	// Reference model.
	// --------------------------------------------------
	function automatic expectT expectFor(input memWbPkg::commandT c,
		input logic [`ADDR_WIDTH-1:0] pcNow, input logic rst);
		expectT                 e;
		logic [IndexWidth-1:0]  index;
		logic [`DATA_WIDTH-1:0] oldWord;
		logic [`DATA_WIDTH-1:0] lane;
		logic [`DATA_WIDTH-1:0] storeValue;
		logic [`DATA_WIDTH-1:0] shifted;
		int                     shift;
		int                     i;
		e = '0;
		index = c.aluResult[2 +: IndexWidth];
		shift = 8 * int'(c.aluResult[1:0]);
		oldWord = modelMem[index];
		lane = oldWord >> shift;
		storeValue = c.forwardStore ? modelLast : modelRegs[c.rs2];
		shifted = storeValue << shift;
		if (rst)
		begin
			e.pcWriteEnable = 1'b1;
			for (i = 0; i < 32; i++)
				modelRegs[i] = '0;
			for (i = 1; i <= `PC_BRANCH_LAG; i++)
				modelPcs[i] = '0;
			modelLast = '0;
		end
		else
		begin
			e.regWrite.rd = c.rd;
			case (c.state)
				memWbPkg::RegWrite:
				begin
					e.regWrite.enable = 1'b1;
					e.regWrite.value  = c.aluResult;
				end
				memWbPkg::LuiRegWrite:
				begin
					e.regWrite.enable = 1'b1;
					e.regWrite.value  = c.imm;
				end
				memWbPkg::MemReadRegWrite:
				begin
					e.regWrite.enable = 1'b1;
					case (c.func3)
						3'd0:    e.regWrite.value = {{24{lane[7]}}, lane[7:0]};
						3'd1:    e.regWrite.value = {{16{lane[15]}}, lane[15:0]};
						3'd4:    e.regWrite.value = {24'd0, lane[7:0]};
						3'd5:    e.regWrite.value = {16'd0, lane[15:0]};
						default: e.regWrite.value = oldWord;
					endcase
				end
				memWbPkg::MemWrite:
				begin
					case (c.func3[1:0])
						2'd0:    e.storeStrobe = 4'(1 << c.aluResult[1:0]);
						2'd1:    e.storeStrobe = 4'(3 << c.aluResult[1:0]);
						default: e.storeStrobe = 4'hF;
					endcase
					for (i = 0; i < 4; i++)
					begin
						if (e.storeStrobe[i])
							oldWord[8*i +: 8] = shifted[8*i +: 8];
					end
					modelMem[index] = oldWord;
				end
				memWbPkg::PcSelectWrite:
				begin
					if (c.aluResult != '0)
					begin
						e.pcWriteEnable = 1'b1;
						e.pcWriteData   = modelPcs[`PC_BRANCH_LAG] + c.imm;
					end
				end
				memWbPkg::PcWrite:
				begin
					e.pcWriteEnable   = 1'b1;
					e.pcWriteData     = c.aluResult;
					e.regWrite.enable = 1'b1;
					e.regWrite.value  = modelPcs[`PC_LINK_LAG];
				end
				default:
				begin
				end
			endcase
			e.resultData = (c.state == memWbPkg::MemWrite) ? storeValue : e.regWrite.value;
			if (e.regWrite.enable && c.rd != '0)
				modelRegs[c.rd] = e.regWrite.value;
			if (c.state != memWbPkg::Idle)
				modelLast = e.resultData;
			for (i = `PC_BRANCH_LAG; i > 1; i--)
				modelPcs[i] = modelPcs[i - 1];
			modelPcs[1] = pcNow;
		end
		return e;
	endfunction

	task automatic compareValue(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("MISMATCH at %0t ns: %s in %s, got %h, expected %h",
				$time, what, testName, actual, expected);
			errorCount++;
			testErrors++;
		end
	endtask

	// Outputs are settled half a cycle after the inputs change.
	initial
	begin
		expectT e;
		forever
		begin
			@(negedge clk);
			e = expectFor(cmd, pc, reset);
			compareValue("pcWriteEnable", 32'(pcWriteEnable), 32'(e.pcWriteEnable));
			if (e.pcWriteEnable)
				compareValue("pcWriteData", pcWriteData, e.pcWriteData);
			compareValue("regWrite.enable", 32'(regWrite.enable), 32'(e.regWrite.enable));
			if (e.regWrite.enable)
			begin
				compareValue("regWrite.rd", 32'(regWrite.rd), 32'(e.regWrite.rd));
				compareValue("regWrite.value", regWrite.value, e.regWrite.value);
			end
			compareValue("storeStrobe", 32'(storeStrobe), 32'(e.storeStrobe));
			if (e.storeStrobe != 4'd0)
				compareValue("storeAddr", storeAddr, cmd.aluResult);
			compareValue("resultData", resultData, e.resultData);
		end
	end

	initial
	begin
		cycleCount = 0;
		while (cycleCount < CycleLimit)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: the run did not finish within %0d cycles", CycleLimit);
		$display("TEST FAILED");
		$finish;
	end

	// --------------------------------------------------
	// Command drivers.
	// --------------------------------------------------
	task automatic sendCommand(input memWbPkg::stateT state, input logic [31:0] alu,
		input logic [31:0] imm, input logic [2:0] func3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [4:0] rd, input logic forward);
		@(posedge clk);
		#2;
		cmd.state        = state;
		cmd.aluResult    = alu;
		cmd.imm          = imm;
		cmd.func3        = func3;
		cmd.rs1          = rs1;
		cmd.rs2          = rs2;
		cmd.rd           = rd;
		cmd.forwardStore = forward;
		pc               = nextPc;
		nextPc           = nextPc + 4;
		commandCount++;
	endtask

	task automatic writeReg(input logic [4:0] rd, input logic [31:0] value);
		sendCommand(memWbPkg::RegWrite, value, 32'd0, 3'd0, 5'd0, 5'd0, rd, 1'b0);
	endtask

	task automatic storeReg(input logic [2:0] func3, input logic [31:0] addr,
		input logic [4:0] rs2);
		sendCommand(memWbPkg::MemWrite, addr, 32'd0, func3, 5'd0, rs2, 5'd0, 1'b0);
	endtask

	task automatic loadReg(input logic [2:0] func3, input logic [31:0] addr,
		input logic [4:0] rd);
		sendCommand(memWbPkg::MemReadRegWrite, addr, 32'd0, func3, 5'd0, 5'd0, rd, 1'b0);
	endtask

	// Every load size and extension at every aligned offset of one word.
	task automatic loadAll(input logic [31:0] base);
		for (int off = 0; off < 4; off++)
		begin
			loadReg(3'd0, base + 32'(off), 5'd9);
			loadReg(3'd4, base + 32'(off), 5'd9);
		end
		for (int off = 0; off < 4; off += 2)
		begin
			loadReg(3'd1, base + 32'(off), 5'd9);
			loadReg(3'd5, base + 32'(off), 5'd9);
		end
		loadReg(3'd2, base, 5'd9);
	endtask

	task automatic sendRandom();
		memWbPkg::stateT state;
		logic [31:0]     alu;
		logic [2:0]      func3;
		logic [3:0]      wordSel;
		logic [1:0]      off;
		state = memWbPkg::stateT'(3'($urandom_range(0, 6)));
		alu = $urandom();
		wordSel = 4'($urandom_range(0, 15));
		func3 = 3'($urandom_range(0, 2));
		off = 2'($urandom_range(0, 3));
		if (func3 == 3'd1)
			off[0] = 1'b0;
		else if (func3 == 3'd2)
			off = 2'd0;
		if (state == memWbPkg::MemReadRegWrite || state == memWbPkg::MemWrite)
			alu = {{(`ADDR_WIDTH-6){1'b0}}, wordSel, off};
		if (state == memWbPkg::MemReadRegWrite && func3 != 3'd2 && $urandom_range(0, 1) == 1)
			func3[2] = 1'b1;
		if (state == memWbPkg::PcSelectWrite && $urandom_range(0, 1) == 1)
			alu = '0;
		nextPc = $urandom() & 32'hFFFF_FFFC;
		sendCommand(state, alu, $urandom(), func3, 5'($urandom_range(0, 31)),
			5'($urandom_range(0, 31)), 5'($urandom_range(0, 31)), 1'($urandom_range(0, 1)));
	endtask

	task automatic finishTest();
		@(posedge clk);
		#2;
		cmd = '0;
		testCount++;
		$display("%-24s %0d errors", testName, testErrors);
		testErrors = 0;
	endtask

	// --------------------------------------------------
	// Test sequence.
	// --------------------------------------------------
	initial
	begin
		void'($urandom(32'h7c531667));
		reset        = 1'b1;
		cmd          = '0;
		pc           = '0;
		nextPc       = 32'h0000_1000;
		errorCount   = 0;
		testErrors   = 0;
		testCount    = 0;
		commandCount = 0;
		testName     = "reset and idle";
		// Live commands during reset must not write anything.
		cmd.aluResult = 32'h0000_0104;
		cmd.imm       = 32'h0000_0040;
		cmd.rs2       = 5'd1;
		cmd.rd        = 5'd3;
		for (int k = 0; k < 5; k++)
		begin
			cmd.state = memWbPkg::stateT'(3'(5 - k));
			@(posedge clk);
			#2;
		end
		cmd   = '0;
		reset = 1'b0;
		repeat (4) sendCommand(memWbPkg::Idle, 32'd0, 32'd0, 3'd0, 5'd0, 5'd0, 5'd0, 1'b0);
		finishTest();

		testName = "register writes";
		writeReg(5'd5, 32'h1234_5678);
		sendCommand(memWbPkg::LuiRegWrite, $urandom(), 32'hABCD_E000, 3'd0, 5'd0, 5'd0,
			5'd6, 1'b0);
		writeReg(5'd0, 32'hDEAD_BEEF);
		storeReg(3'd2, 32'h100, 5'd5);
		storeReg(3'd2, 32'h104, 5'd6);
		storeReg(3'd2, 32'h108, 5'd0);
		finishTest();

		testName = "store and load sizes";
		writeReg(5'd7, 32'h80F1_7F82);
		storeReg(3'd2, 32'h200, 5'd7);
		loadAll(32'h200);
		for (int off = 0; off < 4; off++)
		begin
			writeReg(5'd8, $urandom());
			storeReg(3'd0, 32'h204 + 32'(off), 5'd8);
		end
		loadAll(32'h204);
		for (int off = 0; off < 4; off += 2)
		begin
			writeReg(5'd8, $urandom());
			storeReg(3'd1, 32'h208 + 32'(off), 5'd8);
		end
		loadAll(32'h208);
		finishTest();

		testName = "store forwarding";
		writeReg(5'd10, 32'h5A5A_1234);
		sendCommand(memWbPkg::MemWrite, 32'h300, 32'd0, 3'd2, 5'd0, 5'd0, 5'd0, 1'b1);
		loadReg(3'd2, 32'h300, 5'd12);
		sendCommand(memWbPkg::MemWrite, 32'h304, 32'd0, 3'd2, 5'd0, 5'd0, 5'd0, 1'b1);
		loadReg(3'd2, 32'h304, 5'd13);
		finishTest();

		testName = "branch and jump";
		sendCommand(memWbPkg::PcSelectWrite, 32'd0, 32'h40, 3'd0, 5'd0, 5'd0, 5'd0, 1'b0);
		sendCommand(memWbPkg::PcSelectWrite, 32'd1, 32'h40, 3'd0, 5'd0, 5'd0, 5'd0, 1'b0);
		sendCommand(memWbPkg::PcSelectWrite, 32'd1, 32'hFFFF_FFF0, 3'd0, 5'd0, 5'd0, 5'd0,
			1'b0);
		sendCommand(memWbPkg::PcWrite, 32'h2000, 32'd0, 3'd0, 5'd0, 5'd0, 5'd14, 1'b0);
		storeReg(3'd2, 32'h310, 5'd14);
		sendCommand(memWbPkg::PcWrite, 32'h3000, 32'd0, 3'd0, 5'd0, 5'd0, 5'd0, 1'b0);
		finishTest();

		// Fill every register and the random address window before mixing.
		testName = "random stream";
		for (int r = 1; r < 32; r++)
			writeReg(5'(r), $urandom());
		for (int w = 0; w < 16; w++)
			storeReg(3'd2, 32'(w * 4), 5'($urandom_range(1, 31)));
		repeat (RandomCount) sendRandom();
		finishTest();

		$display("%0d tests, %0d commands, %0d errors", testCount, commandCount, errorCount);
		if (errorCount == 0)
		begin
			$display("TEST PASSED");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: files.f
+incdir+hdl
hdl/memWbPkg.sv
hdl/dataMemory.sv
hdl/registerFile.sv
hdl/memWbController.sv
hdl/memWbUnit.sv
verif/memWbTb.sv

// File: Makefile
# Verilator build and run for the memory and write-back stage.

VERILATOR ?= verilator
TOP       ?= memWbTb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard hdl/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source, header or the file list changes.
$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "TEST PASSED" $(LOG) || { echo "No verdict found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
